//--- spi_pu.f
+incdir+.
spi_pu_pkg.sv
word_buffer.sv
spi_slave_shifter.sv
spi_word_splitter.sv
spi_word_assembler.sv
pu_slave_spi_ctrl.sv
spi_pu_top.sv
spi_pu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI slave unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module spi_pu_tb \
  -f spi_pu.f -o spi_pu_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/spi_pu_sim 2>&1 | tee sim.log
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
  echo "Simulation exited with an error"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
fi
exit 1

//--- spi_pu_tb.sv
`include "spi_pu_config.svh"

module spi_pu_tb;

  localparam int SCLK_HALF  = 8;
  localparam int BW         = `SPI_PU_BYTE_WIDTH;
  localparam int DW         = `SPI_PU_DATA_WIDTH;
  localparam int BYTES      = DW / BW;
  // Five frames of 8 bytes at up to 4000 cycles each
  localparam int MAX_CYCLES = 5 * 4000;

  logic clk, rst, signal_cycle, signal_wr, signal_oe;
  logic mosi, miso, sclk, cs, flag_start, flag_stop;
  spi_pu_pkg::word_t data_in, data_out;
  spi_pu_pkg::word_t tx_words[$];
  spi_pu_pkg::word_t rx_expect[$];
  integer seed;
  int error_count, start_count, stop_count, frame_count, cycle_count;

  spi_pu_top dut0
    ( .clk(clk), .rst(rst), .signal_cycle(signal_cycle), .signal_wr(signal_wr)
    , .data_in(data_in), .signal_oe(signal_oe), .data_out(data_out)
    , .flag_start(flag_start), .flag_stop(flag_stop)
    , .mosi(mosi), .miso(miso), .sclk(sclk), .cs(cs)
    );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////
  // Flag monitoring and run limit

  always @(posedge clk) begin
    if (!rst) begin
      if (flag_start) start_count = start_count + 1;
      if (flag_stop) stop_count = stop_count + 1;
    end
  end

  assert property (@(posedge clk) disable iff (rst) flag_start |=> !flag_start)
    else begin
      error_count = error_count + 1;
      $display("ERROR at %0t: flag_start high for two cycles", $time);
    end

  assert property (@(posedge clk) disable iff (rst) flag_stop |=> !flag_stop)
    else begin
      error_count = error_count + 1;
      $display("ERROR at %0t: flag_stop high for two cycles", $time);
    end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers

  task automatic tick();
    @(posedge clk);
    #5;
  endtask

  // Expected miso byte k, with zeros past the stored words
  function automatic spi_pu_pkg::spi_byte_t expected_tx_byte(input int k);
    spi_pu_pkg::word_t w;
    w = '0;
    if (k / BYTES < tx_words.size()) w = tx_words[k / BYTES];
    return w[(BYTES - 1 - k % BYTES) * BW +: BW];
  endfunction

  // Fill one computation cycle and swap while cs is high
  task automatic write_words(input int n);
    integer rnd;
    int i;
    tx_words.delete();
    for (i = 0; i < n; i++) begin
      rnd = $random(seed);
      data_in = rnd;
      signal_wr = 1'b1;
      tx_words.push_back(rnd);
      tick();
    end
    signal_wr = 1'b0;
    signal_cycle = 1'b1;
    tick();
    signal_cycle = 1'b0;
    repeat (10) tick();
  endtask

  // Mode 0 master sampling miso just before each rising sclk
  task automatic run_frame(input int n_bytes);
    integer rnd;
    spi_pu_pkg::spi_byte_t sent, got;
    spi_pu_pkg::word_t acc;
    int k, b, cnt, n;
    cnt = 0;
    acc = '0;
    cs = 1'b0;
    repeat (SCLK_HALF) tick();
    for (k = 0; k < n_bytes; k++) begin
      rnd = $random(seed);
      sent = rnd[BW-1:0];
      for (b = BW - 1; b >= 0; b--) begin
        mosi = sent[b];
        repeat (SCLK_HALF) tick();
        got[b] = miso;
        sclk = 1'b1;
        repeat (SCLK_HALF) tick();
        sclk = 1'b0;
      end
      assert (got == expected_tx_byte(k)) else begin
        error_count = error_count + 1;
        $display("ERROR at %0t: frame %0d miso byte %0d is %h, expected %h",
                 $time, frame_count, k, got, expected_tx_byte(k));
      end
      acc = {acc[DW-BW-1:0], sent};
      cnt++;
      if (cnt == BYTES) begin
        rx_expect.push_back(acc);
        cnt = 0;
      end
    end
    repeat (SCLK_HALF) tick();
    assert (start_count == frame_count + 1) else begin
      error_count = error_count + 1;
      $display("ERROR at %0t: %0d flag_start pulses after frame %0d",
               $time, start_count, frame_count);
    end
    cs = 1'b1;
    mosi = 1'b0;
    frame_count++;
    n = 0;
    while (stop_count != frame_count && n < 16) begin
      tick();
      n++;
    end
    assert (stop_count == frame_count) else begin
      error_count = error_count + 1;
      $display("ERROR at %0t: %0d flag_stop pulses, expected %0d",
               $time, stop_count, frame_count);
    end
    repeat (6) tick();
  endtask

  // Drain the receive buffer and compare each head word
  task automatic read_rx();
    while (rx_expect.size() > 0) begin
      assert (data_out == rx_expect[0]) else begin
        error_count = error_count + 1;
        $display("ERROR at %0t: data_out %h, expected %h", $time, data_out, rx_expect[0]);
      end
      void'(rx_expect.pop_front());
      signal_oe = 1'b1;
      tick();
      signal_oe = 1'b0;
    end
    assert (data_out == '0) else begin
      error_count = error_count + 1;
      $display("ERROR at %0t: receive buffer holds extra word %h", $time, data_out);
    end
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin
    seed = 32'h5d1c_6d73;
    rst = 1'b1;
    signal_cycle = 1'b0;
    signal_wr = 1'b0;
    signal_oe = 1'b0;
    data_in = '0;
    mosi = 1'b0;
    sclk = 1'b0;
    cs = 1'b1;
    repeat (10) tick();
    rst = 1'b0;
    tick();
    assert (!flag_start && !flag_stop && !miso && data_out == '0) else begin
      error_count = error_count + 1;
      $display("ERROR at %0t: outputs not idle after reset", $time);
    end
    // Only two of four stored words fit in the frame
    write_words(4);
    run_frame(8);
    read_rx();
    // Leftover words of the same buffer must not reappear
    tx_words.delete();
    run_frame(8);
    read_rx();
    // Frame longer than the stored data
    write_words(1);
    run_frame(8);
    read_rx();
    // Frame ends mid-word
    tx_words.delete();
    run_frame(6);
    read_rx();
    write_words(3);
    run_frame(8);
    read_rx();
    $display("Frames: %0d, errors: %0d", frame_count, error_count);
    if (error_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- spi_pu_top.sv
module spi_pu_top
  ( input  logic              clk
  , input  logic              rst
  , input  logic              signal_cycle
  , input  logic              signal_wr
  , input  spi_pu_pkg::word_t data_in
  , input  logic              signal_oe
  , output spi_pu_pkg::word_t data_out
  , output logic              flag_start
  , output logic              flag_stop
  , input  logic              mosi
  , output logic              miso
  , input  logic              sclk
  , input  logic              cs
  );

  logic                  cs_sync, byte_done;
  spi_pu_pkg::spi_byte_t rx_byte, tx_byte;
  spi_pu_pkg::word_t     tx_word, rx_word;
  spi_pu_pkg::word_t     buf0_data, buf1_data;
  logic                  word_req, word_ack, splitter_clr, rx_word_wr;
  logic                  buf0_wr, buf1_wr, buf0_rd, buf1_rd, buf0_clr, buf1_clr;

  ////////////////////////////////////////
  // SPI side

  spi_slave_shifter shifter
    ( .clk(clk), .rst(rst), .sclk(sclk), .cs(cs), .mosi(mosi), .miso(miso)
    , .tx_byte(tx_byte), .rx_byte(rx_byte), .byte_done(byte_done), .cs_sync(cs_sync)
    );

  spi_word_splitter splitter
    ( .clk(clk), .rst(rst), .clr(splitter_clr), .byte_done(byte_done)
    , .tx_word(tx_word), .word_req(word_req), .word_ack(word_ack), .tx_byte(tx_byte)
    );

  spi_word_assembler assembler
    ( .clk(clk), .rst(rst), .cs_sync(cs_sync), .byte_done(byte_done)
    , .rx_byte(rx_byte), .rx_word_wr(rx_word_wr), .rx_word(rx_word)
    );

  ////////////////////////////////////////
  // Control and buffers

  pu_slave_spi_ctrl ctrl
    ( .clk(clk), .rst(rst), .signal_cycle(signal_cycle), .signal_wr(signal_wr)
    , .cs_sync(cs_sync), .word_req(word_req), .word_ack(word_ack), .tx_word(tx_word)
    , .buf0_data(buf0_data), .buf1_data(buf1_data)
    , .buf0_wr(buf0_wr), .buf1_wr(buf1_wr), .buf0_rd(buf0_rd), .buf1_rd(buf1_rd)
    , .buf0_clr(buf0_clr), .buf1_clr(buf1_clr), .splitter_clr(splitter_clr)
    , .flag_start(flag_start), .flag_stop(flag_stop)
    );

  word_buffer tx_buf0
    ( .clk(clk), .rst(rst), .clr(buf0_clr), .wr(buf0_wr), .data_in(data_in)
    , .rd(buf0_rd), .data_out(buf0_data), .empty()
    );

  word_buffer tx_buf1
    ( .clk(clk), .rst(rst), .clr(buf1_clr), .wr(buf1_wr), .data_in(data_in)
    , .rd(buf1_rd), .data_out(buf1_data), .empty()
    );

  // Receive side is never cleared
  word_buffer rx_buf
    ( .clk(clk), .rst(rst), .clr(1'b0), .wr(rx_word_wr), .data_in(rx_word)
    , .rd(signal_oe), .data_out(data_out), .empty()
    );

endmodule

//--- pu_slave_spi_ctrl.sv
module pu_slave_spi_ctrl
  ( input  logic              clk
  , input  logic              rst
  , input  logic              signal_cycle
  , input  logic              signal_wr
  , input  logic              cs_sync
  , input  logic              word_req
  , output logic              word_ack
  , output spi_pu_pkg::word_t tx_word
  , input  spi_pu_pkg::word_t buf0_data
  , input  spi_pu_pkg::word_t buf1_data
  , output logic              buf0_wr
  , output logic              buf1_wr
  , output logic              buf0_rd
  , output logic              buf1_rd
  , output logic              buf0_clr
  , output logic              buf1_clr
  , output logic              splitter_clr
  , output logic              flag_start
  , output logic              flag_stop
  );

  logic                   buf_sel;
  logic                   cs_prev;
  logic                   cs_fall, cs_rise, swap, pop;
  logic                   wait_start, wait_stop;
  logic                   clr_pend, clr_sel;
  spi_pu_pkg::req_state_t req_state;

  assign cs_fall = ~cs_sync & cs_prev;
  assign cs_rise = cs_sync & ~cs_prev;
  // Swap only between frames
  assign swap    = signal_cycle & cs_sync;
  assign pop     = (req_state == spi_pu_pkg::req_idle) & word_req;

  ////////////////////////////////////////
  // Buffer routing

  // buf_sel names the fill buffer, the other one drains
  always_ff @(posedge clk) begin
    if (rst) begin
      buf_sel <= 1'b0;
    end else if (swap) begin
      buf_sel <= ~buf_sel;
    end
  end

  assign buf0_wr  = signal_wr & ~buf_sel;
  assign buf1_wr  = signal_wr & buf_sel;
  assign buf0_rd  = pop & buf_sel;
  assign buf1_rd  = pop & ~buf_sel;
  assign buf0_clr = clr_pend & ~clr_sel;
  assign buf1_clr = clr_pend & clr_sel;

  ////////////////////////////////////////
  // Frame flags and clearing

  always_ff @(posedge clk) begin
    if (rst) begin
      cs_prev      <= 1'b1;
      wait_start   <= 1'b1;
      wait_stop    <= 1'b0;
      flag_start   <= 1'b0;
      flag_stop    <= 1'b0;
      clr_pend     <= 1'b0;
      splitter_clr <= 1'b0;
    end else begin
      cs_prev      <= cs_sync;
      flag_start   <= cs_fall & wait_start;
      flag_stop    <= cs_rise & wait_stop;
      clr_pend     <= flag_stop;
      // A fresh drain buffer needs a fresh first word
      splitter_clr <= flag_stop | swap;
      if (cs_fall && wait_start) begin
        wait_start <= 1'b0;
        wait_stop  <= 1'b1;
      end
      if (cs_rise && wait_stop) begin
        wait_stop  <= 1'b0;
        wait_start <= 1'b1;
      end
    end
  end

  // Drain index at flag_stop, a swap may follow right after
  always_ff @(posedge clk) begin
    if (flag_stop) begin
      clr_sel <= ~buf_sel;
    end
  end

  ////////////////////////////////////////
  // Word acknowledge

  always_ff @(posedge clk) begin
    if (rst) begin
      req_state <= spi_pu_pkg::req_idle;
      word_ack  <= 1'b0;
    end else begin
      case (req_state)
        spi_pu_pkg::req_idle: begin
          if (word_req) begin
            word_ack  <= 1'b1;
            req_state <= spi_pu_pkg::req_wait_ack;
          end
        end
        spi_pu_pkg::req_wait_ack: begin
          if (!word_req) begin
            word_ack  <= 1'b0;
            req_state <= spi_pu_pkg::req_release;
          end
        end
        default: begin
          req_state <= spi_pu_pkg::req_idle;
        end
      endcase
    end
  end

  // Empty drain buffer reads as zero
  always_ff @(posedge clk) begin
    if (pop) begin
      tx_word <= buf_sel ? buf0_data : buf1_data;
    end
  end

endmodule

//--- spi_word_assembler.sv
`include "spi_pu_config.svh"

module spi_word_assembler
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  cs_sync
  , input  logic                  byte_done
  , input  spi_pu_pkg::spi_byte_t rx_byte
  , output logic                  rx_word_wr
  , output spi_pu_pkg::word_t     rx_word
  );

  localparam int DW    = `SPI_PU_DATA_WIDTH;
  localparam int BW    = `SPI_PU_BYTE_WIDTH;
  localparam int BYTES = DW / BW;
  localparam int CNT_W = $clog2(BYTES);

  logic [CNT_W-1:0]  byte_cnt;
  spi_pu_pkg::word_t word_shift, word_next;

  // First byte of a word ends up on top
  assign word_next = {word_shift[DW-BW-1:0], rx_byte};

  // Count held at zero outside a frame, so a partial word is lost
  always_ff @(posedge clk) begin
    if (rst) begin
      byte_cnt   <= '0;
      rx_word_wr <= 1'b0;
    end else begin
      rx_word_wr <= 1'b0;
      if (cs_sync) begin
        byte_cnt <= '0;
      end else if (byte_done) begin
        if (byte_cnt == CNT_W'(BYTES - 1)) begin
          byte_cnt   <= '0;
          rx_word_wr <= 1'b1;
        end else begin
          byte_cnt <= byte_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!cs_sync && byte_done) begin
      word_shift <= word_next;
      if (byte_cnt == CNT_W'(BYTES - 1)) begin
        rx_word <= word_next;
      end
    end
  end

endmodule

//--- spi_word_splitter.sv
`include "spi_pu_config.svh"

module spi_word_splitter
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  clr
  , input  logic                  byte_done
  , input  spi_pu_pkg::word_t     tx_word
  , output logic                  word_req
  , input  logic                  word_ack
  , output spi_pu_pkg::spi_byte_t tx_byte
  );

  localparam int BW    = `SPI_PU_BYTE_WIDTH;
  localparam int BYTES = `SPI_PU_DATA_WIDTH / `SPI_PU_BYTE_WIDTH;
  localparam int IDX_W = $clog2(BYTES);

  spi_pu_pkg::word_t word_q;
  logic [IDX_W-1:0]  byte_idx;
  logic              loaded;

  // Requester side of the word handshake
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      byte_idx <= '0;
      loaded   <= 1'b0;
      word_req <= 1'b0;
    end else begin
      if (word_req && word_ack) begin
        byte_idx <= '0;
        loaded   <= 1'b1;
        word_req <= 1'b0;
      end else if (!loaded && !word_req && !word_ack) begin
        // Previous ack must be gone first
        word_req <= 1'b1;
      end
      if (byte_done && loaded) begin
        if (byte_idx == IDX_W'(BYTES - 1)) begin
          byte_idx <= '0;
          loaded   <= 1'b0;
        end else begin
          byte_idx <= byte_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (word_req && word_ack) begin
      word_q <= tx_word;
    end
  end

  // Most significant byte first, zero while no word is held
  always_comb begin
    tx_byte = '0;
    if (loaded) begin
      tx_byte = word_q[(BYTES - 1 - int'(byte_idx)) * BW +: BW];
    end
  end

endmodule

//--- spi_slave_shifter.sv
`include "spi_pu_config.svh"

module spi_slave_shifter
  ( input  logic                  clk
  , input  logic                  rst
  , input  logic                  sclk
  , input  logic                  cs
  , input  logic                  mosi
  , output logic                  miso
  , input  spi_pu_pkg::spi_byte_t tx_byte
  , output spi_pu_pkg::spi_byte_t rx_byte
  , output logic                  byte_done
  , output logic                  cs_sync
  );

  localparam int BW    = `SPI_PU_BYTE_WIDTH;
  localparam int CNT_W = $clog2(BW);

  logic                  sclk_meta, sclk_s, sclk_prev;
  logic                  cs_meta, cs_s, cs_prev;
  logic                  mosi_meta, mosi_s;
  logic                  sclk_rise, sclk_fall, cs_fall;
  logic [CNT_W-1:0]      bit_cnt;
  spi_pu_pkg::spi_byte_t rx_shift, rx_next, tx_shift;

  ////////////////////////////////////////
  // Pin synchronizers

  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_meta <= 1'b0;
      sclk_s    <= 1'b0;
      sclk_prev <= 1'b0;
      cs_meta   <= 1'b1;
      cs_s      <= 1'b1;
      cs_prev   <= 1'b1;
    end else begin
      sclk_meta <= sclk;
      sclk_s    <= sclk_meta;
      sclk_prev <= sclk_s;
      cs_meta   <= cs;
      cs_s      <= cs_meta;
      cs_prev   <= cs_s;
    end
  end

  always_ff @(posedge clk) begin
    mosi_meta <= mosi;
    mosi_s    <= mosi_meta;
  end

  assign sclk_rise = sclk_s & ~sclk_prev;
  assign sclk_fall = ~sclk_s & sclk_prev;
  assign cs_fall   = ~cs_s & cs_prev;
  assign rx_next   = {rx_shift[BW-2:0], mosi_s};
  assign cs_sync   = cs_s;
  // Line stays low outside a frame
  assign miso      = tx_shift[BW-1] & ~cs_s;

  ////////////////////////////////////////
  // Mode 0 shifting

  always_ff @(posedge clk) begin
    if (rst) begin
      bit_cnt   <= '0;
      byte_done <= 1'b0;
      tx_shift  <= '0;
    end else begin
      byte_done <= 1'b0;
      if (cs_s) begin
        bit_cnt <= '0;
      end else if (cs_fall) begin
        bit_cnt  <= '0;
        tx_shift <= tx_byte;
      end else begin
        if (sclk_rise) begin
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == CNT_W'(BW - 1)) begin
            byte_done <= 1'b1;
          end
        end
        // Count back at zero means the byte just ended
        if (sclk_fall) begin
          tx_shift <= (bit_cnt == '0) ? tx_byte : {tx_shift[BW-2:0], 1'b0};
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!cs_s && sclk_rise) begin
      rx_shift <= rx_next;
      if (bit_cnt == CNT_W'(BW - 1)) begin
        rx_byte <= rx_next;
      end
    end
  end

endmodule

//--- word_buffer.sv
`include "spi_pu_config.svh"

module word_buffer
  ( input  logic              clk
  , input  logic              rst
  , input  logic              clr
  , input  logic              wr
  , input  spi_pu_pkg::word_t data_in
  , input  logic              rd
  , output spi_pu_pkg::word_t data_out
  , output logic              empty
  );

  localparam int DEPTH = `SPI_PU_BUF_DEPTH;
  localparam int CNT_W = $clog2(DEPTH + 1);

  spi_pu_pkg::word_t    mem [DEPTH];
  spi_pu_pkg::buf_ptr_t wr_ptr, rd_ptr;
  logic [CNT_W-1:0]     count;
  logic                 full, do_wr, do_rd;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  // Full and empty accesses are simply ignored
  assign do_wr = wr & ~full;
  assign do_rd = rd & ~empty;

  always_ff @(posedge clk) begin
    if (rst || clr) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == spi_pu_pkg::buf_ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == spi_pu_pkg::buf_ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Head word, zero when nothing is stored
  assign data_out = empty ? '0 : mem[rd_ptr];

endmodule

//--- spi_pu_pkg.sv
`include "spi_pu_config.svh"

package spi_pu_pkg;

  // Processor data word
  typedef logic [`SPI_PU_DATA_WIDTH-1:0] word_t;

  // Byte on the SPI wires
  typedef logic [`SPI_PU_BYTE_WIDTH-1:0] spi_byte_t;

  // Index into a word buffer
  typedef logic [$clog2(`SPI_PU_BUF_DEPTH)-1:0] buf_ptr_t;

  // Acknowledge side of the splitter word request
  typedef enum logic [1:0] {
    req_idle,
    req_wait_ack,
    req_release
  } req_state_t;

endpackage

//--- spi_pu_config.svh
`ifndef SPI_PU_CONFIG_SVH
`define SPI_PU_CONFIG_SVH

////////////////////////////////////////
// Word and transfer widths

// Processor word
`define SPI_PU_DATA_WIDTH 32

// One SPI transfer unit
`define SPI_PU_BYTE_WIDTH 8

////////////////////////////////////////
// Buffer sizing

`define SPI_PU_BUF_DEPTH 6

`endif
